// File: files.f
hdl/rtg_video_pkg.sv
hdl/rtg_scan_timing.sv
hdl/rtg_clut.sv
hdl/rtg_video_mixer.sv
hdl/rtg_video_top.sv
sim/tb_rtg_video.sv

// File: hdl/rtg_clut.sv
////////////////////////////////////////
// 256 entry palette with 24 bit colour
// Contents are undefined until written
////////////////////////////////////////

module rtg_clut import rtg_video_pkg::*; (
  input  logic                  CLK_114,
  input  clut_wr_t              clut_wr,
  input  logic [CLUT_IDX_W-1:0] rd_idx,
  output rgb_t                  rd_rgb
);

  rgb_t palette [CLUT_DEPTH];  // Colour table

  ////////////////////////////////////////
  // Write port
  ////////////////////////////////////////

  // Write lands on the edge after the strobe is seen
  always_ff @(posedge CLK_114) begin
    if (clut_wr.strobe)
      palette[clut_wr.idx] <= clut_wr.value;
  end

  ////////////////////////////////////////
  // Read port
  ////////////////////////////////////////

  assign rd_rgb = palette[rd_idx];  // Combinational lookup

endmodule

// File: hdl/rtg_scan_timing.sv
////////////////////////////////////////
// Vertical blank extension and pixel fetch cadence
// fetch is combinational and single cycle with no back-pressure
// pixel_width and vb_end are treated as quasi-static
////////////////////////////////////////

module rtg_scan_timing import rtg_video_pkg::*; (
  input  logic         CLK_114,
  input  logic         reset,
  input  rtg_cfg_t     cfg,
  input  logic         hsync,
  input  logic         hblank,
  input  logic         vblank,
  output scan_timing_t timing
);

  scan_phase_e          phase;      // Vertical scan phase
  logic [VB_CNT_W-1:0]  vb_cnt;     // Hsync edges since vblank fell
  logic                 hsync_d;    // For rising edge detect
  logic [PIX_CNT_W-1:0] pix_cnt;    // Clocks since last fetch
  logic                 byte_flag;  // Second half of the fetch period
  logic                 byte_d;     // Aligned with the word in use
  logic                 blank_d;    // Blank one clock ago
  logic                 blank;
  logic                 fetch;
  logic                 hs_rise;
  logic [PIX_CNT_W-1:0] half_width; // Counter value for byte switch

  ////////////////////////////////////////
  // Vertical blank extension
  ////////////////////////////////////////

  assign hs_rise = hsync & ~hsync_d;

  always_ff @(posedge CLK_114) begin
    if (reset) begin
      phase   <= phase_vblank;
      vb_cnt  <= '0;
      hsync_d <= 1'b0;
    end else begin
      hsync_d <= hsync;
      if (vblank) begin                 // Chipset vblank restarts the count
        phase  <= phase_vblank;
        vb_cnt <= '0;
      end else if (vb_cnt == cfg.vb_end) begin
        phase <= phase_active;
      end else if (hs_rise) begin
        vb_cnt <= vb_cnt + 1'b1;        // One more line of extended blank
      end
    end
  end

  assign blank = (phase == phase_vblank) | hblank;

  ////////////////////////////////////////
  // Fetch counter and strobe
  ////////////////////////////////////////

  // Strobe on the last clock of each fetch period; with ext the
  // first blank clock still gets one fetch
  assign fetch = cfg.ena
               & (~blank | (~blank_d & cfg.ext))
               & (pix_cnt == cfg.pixel_width);

  assign half_width = {1'b0, cfg.pixel_width[PIX_CNT_W-1:1]};

  always_ff @(posedge CLK_114) begin
    if (reset) begin
      pix_cnt   <= '0;
      byte_flag <= 1'b0;
      byte_d    <= 1'b0;
      blank_d   <= 1'b1;                // Keeps fetch low out of reset
    end else begin
      blank_d <= blank;
      byte_d  <= byte_flag;
      if (blank || fetch) begin         // New period starts
        pix_cnt   <= '0;
        byte_flag <= 1'b0;
      end else begin
        pix_cnt <= pix_cnt + 1'b1;
        if (pix_cnt == half_width)
          byte_flag <= 1'b1;            // Switch to the low byte
      end
    end
  end

  assign timing.blank    = blank;
  assign timing.fetch    = fetch;
  assign timing.byte_sel = byte_d;

endmodule

// File: hdl/rtg_video_mixer.sv
////////////////////////////////////////
// RTG or chipset colour into the output register
// One cycle from inputs to vid_out
// OSD overlay sits after the register
////////////////////////////////////////

module rtg_video_mixer import rtg_video_pkg::*; (
  input  logic                  CLK_114,
  input  logic                  reset,
  input  rtg_cfg_t              cfg,
  input  scan_timing_t          timing,
  input  logic [WORD_W-1:0]     pix_word,
  output logic [CLUT_IDX_W-1:0] clut_idx,
  input  rgb_t                  clut_rgb,
  input  chip_video_t           chip_video,
  input  logic                  osd_window,
  input  logic                  osd_pixel,
  output chip_video_t           vid_out
);

  rgb_t        hicolor;   // Expanded RGB565
  rgb_t        rtg_rgb;   // Palette or hi-colour
  rgb_t        mix_rgb;   // RTG or chipset
  chip_video_t vid_q;     // Output register
  logic [1:0]  osd_r;
  logic [1:0]  osd_g;
  logic [1:0]  osd_b;

  ////////////////////////////////////////
  // Hi-colour expansion
  ////////////////////////////////////////

  // Top bits repeat into the low bits so full scale stays full scale
  function automatic rgb_t expand_565(input logic [WORD_W-1:0] w);
    rgb_t c;
    c.r = {w[15:11], w[15:13]};  // 5 to 8 bits
    c.g = {w[10:5], w[10:9]};    // 6 to 8 bits
    c.b = {w[4:0], w[4:2]};      // 5 to 8 bits
    return c;
  endfunction

  assign hicolor = expand_565(pix_word);

  // High byte first, low byte once byte_sel rises
  assign clut_idx = timing.byte_sel ? pix_word[7:0] : pix_word[15:8];

  assign rtg_rgb = cfg.clut_mode ? clut_rgb : hicolor;

  assign mix_rgb = (cfg.ena && !timing.blank) ? rtg_rgb : chip_video.color;

  ////////////////////////////////////////
  // Output register
  ////////////////////////////////////////

  always_ff @(posedge CLK_114) begin
    if (reset) begin
      vid_q <= '0;
    end else begin
      vid_q.csync <= chip_video.csync;  // Syncs delayed to match colour
      vid_q.hsync <= chip_video.hsync;
      vid_q.vsync <= chip_video.vsync;
      vid_q.color <= mix_rgb;
    end
  end

  ////////////////////////////////////////
  // OSD overlay
  ////////////////////////////////////////

  assign osd_r = osd_pixel ? OSD_ON_R : OSD_OFF_R;
  assign osd_g = osd_pixel ? OSD_ON_G : OSD_OFF_G;
  assign osd_b = osd_pixel ? OSD_ON_B : OSD_OFF_B;

  assign vid_out.csync = vid_q.csync;
  assign vid_out.hsync = vid_q.hsync;
  assign vid_out.vsync = vid_q.vsync;

  // Overlay replaces the top two bits and keeps the rest of the picture
  assign vid_out.color.r = osd_window ? {osd_r, vid_q.color.r[COLOR_W-3:0]}
                                      : vid_q.color.r;
  assign vid_out.color.g = osd_window ? {osd_g, vid_q.color.g[COLOR_W-3:0]}
                                      : vid_q.color.g;
  assign vid_out.color.b = osd_window ? {osd_b, vid_q.color.b[COLOR_W-3:0]}
                                      : vid_q.color.b;

endmodule

// File: hdl/rtg_video_pkg.sv
////////////////////////////////////////
// Shared types and constants for the RTG video path
// Sync levels in chip_video_t are active high
// OSD colours cover the top two bits of each channel only
////////////////////////////////////////

package rtg_video_pkg;

  ////////////////////////////////////////
  // Widths and sizes
  ////////////////////////////////////////

  localparam int COLOR_W    = 8;    // One colour channel
  localparam int CLUT_IDX_W = 8;    // Palette index
  localparam int CLUT_DEPTH = 256;  // Palette entries
  localparam int PIX_CNT_W  = 3;    // Fetch counter and pixel_width
  localparam int VB_CNT_W   = 5;    // Vblank extension counter and vb_end
  localparam int WORD_W     = 16;   // Pixel word from the source

  ////////////////////////////////////////
  // OSD overlay colours
  ////////////////////////////////////////

  localparam logic [1:0] OSD_ON_R  = 2'b11;  // White where the OSD pixel is set
  localparam logic [1:0] OSD_ON_G  = 2'b11;
  localparam logic [1:0] OSD_ON_B  = 2'b11;
  localparam logic [1:0] OSD_OFF_R = 2'b00;  // Dark blue background
  localparam logic [1:0] OSD_OFF_G = 2'b00;
  localparam logic [1:0] OSD_OFF_B = 2'b10;

  ////////////////////////////////////////
  // Bundles
  ////////////////////////////////////////

  typedef struct packed {
    logic [COLOR_W-1:0] r;
    logic [COLOR_W-1:0] g;
    logic [COLOR_W-1:0] b;
  } rgb_t;  // 24 bits

  typedef struct packed {
    logic csync;
    logic hsync;
    logic vsync;
    rgb_t color;
  } chip_video_t;  // 27 bits

  typedef struct packed {
    logic                 ena;          // RTG screen on
    logic                 clut_mode;    // Indexed colour
    logic                 ext;          // One extra clock of active area
    logic [PIX_CNT_W-1:0] pixel_width;  // Clocks per fetch minus one
    logic [VB_CNT_W-1:0]  vb_end;       // Hsync edges of extended vblank
  } rtg_cfg_t;  // 11 bits

  typedef struct packed {
    logic                  strobe;  // Write on the next edge
    logic [CLUT_IDX_W-1:0] idx;
    rgb_t                  value;
  } clut_wr_t;  // 33 bits

  typedef struct packed {
    logic blank;     // Vblank phase or hblank
    logic fetch;     // Take the next pixel word
    logic byte_sel;  // Low byte as palette index
  } scan_timing_t;  // 3 bits

  typedef enum logic {
    phase_vblank = 1'b0,
    phase_active = 1'b1
  } scan_phase_e;

endpackage

// File: hdl/rtg_video_top.sv
////////////////////////////////////////
// RTG video output path
// pix_word must be a show-ahead source that is never empty
// while fetching
////////////////////////////////////////

module rtg_video_top import rtg_video_pkg::*; (
  input  logic              CLK_114,
  input  logic              reset,
  input  rtg_cfg_t          cfg,
  input  clut_wr_t          clut_wr,
  input  chip_video_t       chip_video,
  input  logic              hblank,
  input  logic              vblank,
  input  logic              osd_window,
  input  logic              osd_pixel,
  input  logic [WORD_W-1:0] pix_word,
  output logic              fetch,
  output chip_video_t       vid_out
);

  scan_timing_t          timing;    // Timing to mixer
  logic [CLUT_IDX_W-1:0] clut_idx;  // Mixer to palette
  rgb_t                  clut_rgb;  // Palette to mixer

  ////////////////////////////////////////
  // Scan timing and palette
  ////////////////////////////////////////

  rtg_scan_timing u_timing (
    .CLK_114 (CLK_114),
    .reset   (reset),
    .cfg     (cfg),
    .hsync   (chip_video.hsync),  // Edge counting for vblank extension
    .hblank  (hblank),
    .vblank  (vblank),
    .timing  (timing)
  );

  rtg_clut u_clut (
    .CLK_114 (CLK_114),
    .clut_wr (clut_wr),
    .rd_idx  (clut_idx),
    .rd_rgb  (clut_rgb)
  );

  ////////////////////////////////////////
  // Mixer
  ////////////////////////////////////////

  rtg_video_mixer u_mixer (
    .CLK_114    (CLK_114),
    .reset      (reset),
    .cfg        (cfg),
    .timing     (timing),
    .pix_word   (pix_word),
    .clut_idx   (clut_idx),
    .clut_rgb   (clut_rgb),
    .chip_video (chip_video),
    .osd_window (osd_window),
    .osd_pixel  (osd_pixel),
    .vid_out    (vid_out)
  );

  assign fetch = timing.fetch;  // Word source advances on this

endmodule

// File: run_sim.sh
#!/bin/sh
# Build and run the RTG video testbench with Verilator.
# Exit status is nonzero when the build, the run or the checks fail.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir
TOP=tb_rtg_video

verilator --binary --timing --timescale 1ns/100ps -j 0 \
  --top-module "$TOP" -Mdir "$OBJ" -f files.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$OBJ/V$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Test FAILED" "$LOG"; then
  exit 1
fi
if ! grep -q "Test OK" "$LOG"; then
  echo "Simulation log has no result line"
  exit 1
fi
exit 0

// File: sim/tb_rtg_video.sv
////////////////////////////////////////
// Testbench for the RTG video path on a small raster
// Word source is show-ahead and always holds four words
// Palette is fully loaded before any indexed colour frame
////////////////////////////////////////

module tb_rtg_video import rtg_video_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  ////////////////////////////////////////
  // Raster and run length
  ////////////////////////////////////////

  localparam int LINE_CYC     = 40;  // Clocks per line
  localparam int HBLANK_CYC   = 8;   // Blank at line start
  localparam int HSYNC_START  = 2;   // Sync inside hblank
  localparam int HSYNC_END    = 5;
  localparam int FRAME_LINES  = 12;
  localparam int VBLANK_LINES = 2;   // Vblank at frame start
  localparam int FRAME_CYC    = LINE_CYC * FRAME_LINES;
  localparam int RESET_CYC    = 8;
  localparam int N_FRAMES     = 13;
  localparam int RUN_CYC      = RESET_CYC + CLUT_DEPTH + N_FRAMES * FRAME_CYC + 4;
  localparam int TIMEOUT_CYC  = RUN_CYC * 12 / 10;  // 20% margin
  localparam logic [31:0] SEED      = 32'h7390;
  localparam logic [31:0] LFSR_TAPS = 32'hA300_0000;  // Right-shift Galois form

  logic              CLK_114;
  logic              reset;
  rtg_cfg_t          cfg;
  clut_wr_t          clut_wr;
  chip_video_t       chip_video;
  logic              hblank;
  logic              vblank;
  logic              osd_window;
  logic              osd_pixel;
  logic [WORD_W-1:0] pix_word;
  logic              fetch;
  chip_video_t       vid_out;

  logic [31:0]       lfsr_state;
  logic [WORD_W-1:0] word_q [$];       // Show-ahead source with its head on pix_word
  logic              fetch_seen;       // Fetch sampled mid-cycle
  string             test_name;
  int                errors = 0;
  int                checks = 0;
  int                cycle_cnt = 0;

  ////////////////////////////////////////
  // Cycle model state
  ////////////////////////////////////////

  scan_phase_e          m_phase;
  logic [VB_CNT_W-1:0]  m_vb_cnt;
  logic                 m_hsync_d;
  logic [PIX_CNT_W-1:0] m_pix;
  logic                 m_byte_flag;
  logic                 m_byte_d;
  logic                 m_blank_d;
  chip_video_t          m_vid;             // Registered video before OSD
  logic                 model_valid = 1'b0;  // Set once reset is modelled
  rgb_t                 pal_copy [CLUT_DEPTH];

  rtg_video_top uut (
    .CLK_114    (CLK_114),
    .reset      (reset),
    .cfg        (cfg),
    .clut_wr    (clut_wr),
    .chip_video (chip_video),
    .hblank     (hblank),
    .vblank     (vblank),
    .osd_window (osd_window),
    .osd_pixel  (osd_pixel),
    .pix_word   (pix_word),
    .fetch      (fetch),
    .vid_out    (vid_out)
  );

  initial begin
    CLK_114 = 1'b0;
    forever #5 CLK_114 = ~CLK_114;  // 10 ns period
  end

  ////////////////////////////////////////
  // Random bits and helpers
  ////////////////////////////////////////

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0])
      return (s >> 1) ^ LFSR_TAPS;
    else
      return s >> 1;
  endfunction

  // One LFSR step per bit and the first bit lands on top
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] r;
    logic        b;
    r = '0;
    for (int i = 0; i < n; i++) begin
      b          = lfsr_state[0];
      lfsr_state = lfsr_next(lfsr_state);
      r          = {r[30:0], b};
    end
    return r;
  endfunction

  function automatic rtg_cfg_t make_cfg(input logic ena, input logic clut_mode,
                                        input logic ext, input logic [PIX_CNT_W-1:0] pw,
                                        input logic [VB_CNT_W-1:0] vb);
    rtg_cfg_t c;
    c.ena         = ena;
    c.clut_mode   = clut_mode;
    c.ext         = ext;
    c.pixel_width = pw;
    c.vb_end      = vb;
    return c;
  endfunction

  ////////////////////////////////////////
  // Reference functions
  ////////////////////////////////////////

  function automatic rgb_t expand_rgb565(input logic [WORD_W-1:0] w);
    logic [4:0] r5;
    logic [5:0] g6;
    logic [4:0] b5;
    rgb_t       c;
    r5  = w[15:11];
    g6  = w[10:5];
    b5  = w[4:0];
    c.r = {r5, r5[4:2]};  // Top bits fill the low end
    c.g = {g6, g6[5:4]};
    c.b = {b5, b5[4:2]};
    return c;
  endfunction

  function automatic logic model_blank();
    return (m_phase == phase_vblank) || hblank;
  endfunction

  function automatic logic model_fetch();
    logic open;
    open = !model_blank() || (!m_blank_d && cfg.ext);  // Extra slot as blank rises
    return cfg.ena && open && (m_pix == cfg.pixel_width);
  endfunction

  function automatic rgb_t mix_color(input logic blank, input logic [WORD_W-1:0] w);
    logic [CLUT_IDX_W-1:0] idx;
    rgb_t                  rtg;
    idx = m_byte_d ? w[7:0] : w[15:8];  // High byte first
    rtg = cfg.clut_mode ? pal_copy[idx] : expand_rgb565(w);
    if (cfg.ena && !blank)
      return rtg;
    else
      return chip_video.color;
  endfunction

  function automatic chip_video_t apply_osd(input chip_video_t v, input logic win,
                                            input logic pix);
    chip_video_t o;
    o = v;
    if (win) begin
      o.color.r[7:6] = pix ? OSD_ON_R : OSD_OFF_R;
      o.color.g[7:6] = pix ? OSD_ON_G : OSD_OFF_G;
      o.color.b[7:6] = pix ? OSD_ON_B : OSD_OFF_B;
    end
    return o;
  endfunction

  // Applies the coming clock edge to the model
  task automatic step_model();
    logic blank;
    logic fetch_x;
    logic hs_rise;
    if (reset) begin
      m_phase     = phase_vblank;
      m_vb_cnt    = '0;
      m_hsync_d   = 1'b0;
      m_pix       = '0;
      m_byte_flag = 1'b0;
      m_byte_d    = 1'b0;
      m_blank_d   = 1'b1;  // No fetch right after reset
      m_vid       = '0;
      model_valid = 1'b1;
    end else begin
      blank   = model_blank();
      fetch_x = model_fetch();
      hs_rise = chip_video.hsync && !m_hsync_d;
      m_vid.csync = chip_video.csync;
      m_vid.hsync = chip_video.hsync;
      m_vid.vsync = chip_video.vsync;
      m_vid.color = mix_color(blank, pix_word);  // Palette read before the write lands
      if (vblank) begin
        m_phase  = phase_vblank;
        m_vb_cnt = '0;
      end else if (m_vb_cnt == cfg.vb_end) begin
        m_phase = phase_active;
      end else if (hs_rise) begin
        m_vb_cnt = m_vb_cnt + 1'b1;
      end
      m_hsync_d = chip_video.hsync;
      m_blank_d = blank;
      m_byte_d  = m_byte_flag;
      if (blank || fetch_x) begin
        m_pix       = '0;
        m_byte_flag = 1'b0;
      end else begin
        if (m_pix == (cfg.pixel_width >> 1))
          m_byte_flag = 1'b1;  // Low byte from here on
        m_pix = m_pix + 1'b1;
      end
    end
    if (clut_wr.strobe)
      pal_copy[clut_wr.idx] = clut_wr.value;
  endtask

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("Fail %s %s: expected %h, actual %h", test_name, what, expected, actual);
    end
  endtask

  ////////////////////////////////////////
  // Comparing process
  ////////////////////////////////////////

  // Inputs have settled by mid-cycle
  always @(negedge CLK_114) begin
    fetch_seen = fetch;
    if (model_valid) begin
      check_value("fetch", {31'b0, model_fetch()}, {31'b0, fetch});
      check_value("vid_out", {5'b0, apply_osd(m_vid, osd_window, osd_pixel)},
                  {5'b0, vid_out});
    end
    step_model();
  end

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  task automatic advance_word();
    logic [31:0] r;
    if (fetch_seen) begin  // Next word shows the cycle after a fetch
      void'(word_q.pop_front());
      r = take_bits(WORD_W);
      word_q.push_back(r[WORD_W-1:0]);
    end
    pix_word = word_q[0];
  endtask

  task automatic drive_raster(input int h, input int v, input logic osd_rand);
    logic [31:0] r;
    hblank           = (h < HBLANK_CYC);
    vblank           = (v < VBLANK_LINES);
    chip_video.hsync = (h >= HSYNC_START) && (h < HSYNC_END);
    chip_video.vsync = vblank;
    chip_video.csync = chip_video.hsync | chip_video.vsync;
    r                = take_bits(24);
    chip_video.color = r[23:0];
    r                = take_bits(2);
    osd_window       = osd_rand & r[1];
    osd_pixel        = r[0];
  endtask

  task automatic load_palette();
    logic [31:0] r;
    for (int i = 0; i < CLUT_DEPTH; i++) begin
      @(posedge CLK_114);
      #1;
      advance_word();
      drive_raster(0, 0, 1'b0);  // Held in blank while loading
      r              = take_bits(24);
      clut_wr.strobe = 1'b1;
      clut_wr.idx    = i[7:0];
      clut_wr.value  = r[23:0];
    end
    @(posedge CLK_114);
    #1;
    clut_wr.strobe = 1'b0;
  endtask

  task automatic run_frame(input string name, input rtg_cfg_t c, input logic osd_rand);
    for (int cyc = 0; cyc < FRAME_CYC; cyc++) begin
      @(posedge CLK_114);
      #1;
      if (cyc == 0) begin  // New config while vblank is high
        test_name = name;
        cfg       = c;
      end
      advance_word();
      drive_raster(cyc % LINE_CYC, cyc / LINE_CYC, osd_rand);
    end
  endtask

  initial begin
    logic [31:0] r;
    reset      = 1'b1;
    cfg        = make_cfg(1'b0, 1'b0, 1'b0, 3'd0, 5'd0);
    clut_wr    = '0;
    chip_video = '0;
    hblank     = 1'b1;
    vblank     = 1'b1;
    osd_window = 1'b0;
    osd_pixel  = 1'b0;
    fetch_seen = 1'b0;
    test_name  = "reset";
    lfsr_state = SEED;
    for (int i = 0; i < 4; i++) begin
      r = take_bits(WORD_W);
      word_q.push_back(r[WORD_W-1:0]);
    end
    pix_word = word_q[0];
    repeat (RESET_CYC) @(posedge CLK_114);
    #1;
    reset     = 1'b0;
    test_name = "clut_load";
    load_palette();
    run_frame("passthru", make_cfg(1'b0, 1'b0, 1'b0, 3'd0, 5'd0), 1'b0);
    run_frame("cadence_w0", make_cfg(1'b1, 1'b0, 1'b0, 3'd0, 5'd0), 1'b0);
    run_frame("cadence_w0_ext", make_cfg(1'b1, 1'b0, 1'b1, 3'd0, 5'd0), 1'b0);
    run_frame("cadence_w3", make_cfg(1'b1, 1'b0, 1'b0, 3'd3, 5'd0), 1'b0);
    run_frame("cadence_w3_ext", make_cfg(1'b1, 1'b0, 1'b1, 3'd3, 5'd0), 1'b0);
    run_frame("cadence_w7", make_cfg(1'b1, 1'b0, 1'b0, 3'd7, 5'd0), 1'b0);
    run_frame("cadence_w7_ext", make_cfg(1'b1, 1'b0, 1'b1, 3'd7, 5'd0), 1'b0);
    run_frame("vb_end_5", make_cfg(1'b1, 1'b0, 1'b0, 3'd1, 5'd5), 1'b0);
    run_frame("clut_w3", make_cfg(1'b1, 1'b1, 1'b0, 3'd3, 5'd0), 1'b0);
    run_frame("clut_w7_ext", make_cfg(1'b1, 1'b1, 1'b1, 3'd7, 5'd5), 1'b0);
    run_frame("osd_rtg", make_cfg(1'b1, 1'b0, 1'b0, 3'd2, 5'd0), 1'b1);
    run_frame("osd_clut", make_cfg(1'b1, 1'b1, 1'b0, 3'd3, 5'd0), 1'b1);
    run_frame("osd_chip", make_cfg(1'b0, 1'b0, 1'b0, 3'd0, 5'd0), 1'b1);
    repeat (2) @(negedge CLK_114);  // Last cycles still get compared
    #1;
    $display("Errors: %0d, checks: %0d", errors, checks);
    if (errors == 0 && checks > 0)
      $display("Test OK");
    else
      $display("Test FAILED");
    $finish;
  end

  // Run length bound from the frame count
  initial begin
    while (cycle_cnt < TIMEOUT_CYC) begin
      @(posedge CLK_114);
      cycle_cnt++;
    end
    $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYC);
    $display("Test FAILED");
    $finish;
  end

endmodule
